// ==== Makefile ====
# Verilator build and run for the correlated branch predictor

VERILATOR ?= verilator
FILELIST  ?= correlatedPredictor.f
TB_TOP    ?= correlatedPredictorTb
RTL_TOP   ?= correlatedPredictor
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== correlatedPredictor.f ====
rtl/predictorCfgPkg.sv
rtl/counterPkg.sv
rtl/counterPortIf.sv
rtl/counterTable.sv
rtl/counterUpdate.sv
rtl/decodeLookup.sv
rtl/correlatedPredictor.sv
test/clockGen.sv
test/correlatedPredictorTb.sv

// ==== rtl/correlatedPredictor.sv ====
`default_nettype none

module correlatedPredictor import predictorCfgPkg::*; (
  input  logic clock,
  input  logic arstN,

  // Global history bit that gates training
  input  logic historyBit,

  // Execute stage, resolving a branch
  input  pc_t  xPc,
  input  logic xBranch,
  input  logic predictedTaken,
  input  logic predictedWrong,

  // Decode stage, asking for a prediction
  input  pc_t  dPc,
  input  logic dBranch,
  output logic shouldTakeBranch
);

  counterPortIf portIf ();

  counterTable counterTable_inst (
    .clock (clock),
    .arstN (arstN),
    .port  (portIf.tablePort)
  );

  counterUpdate counterUpdate_inst (
    .xPc            (xPc),
    .xBranch        (xBranch),
    .historyBit     (historyBit),
    .predictedTaken (predictedTaken),
    .predictedWrong (predictedWrong),
    .port           (portIf.updater)
  );

  // Prediction is combinational and sees this cycle's write when the index matches
  decodeLookup decodeLookup_inst (
    .dPc              (dPc),
    .dBranch          (dBranch),
    .shouldTakeBranch (shouldTakeBranch),
    .port             (portIf.lookup)
  );

endmodule

`default_nettype wire

// ==== rtl/counterPkg.sv ====
`default_nettype none

package counterPkg;

  localparam int counterWidth = 2;

  // Numeric order is the saturating order, so the upper bit is the predicted direction
  typedef enum logic [counterWidth-1:0] {
    strongNotTaken = 2'b00,
    weakNotTaken   = 2'b01,
    weakTaken      = 2'b10,
    strongTaken    = 2'b11
  } counterState_t;

  localparam counterState_t counterResetState = strongNotTaken;

  // Branch direction as known in the execute stage
  typedef logic direction_t;

  localparam direction_t dirNotTaken = 1'b0;
  localparam direction_t dirTaken    = 1'b1;

  // Both taken states predict taken, whatever their strength
  function automatic logic predictsTaken(input counterState_t state);
    return (state == weakTaken) || (state == strongTaken);
  endfunction

endpackage

`default_nettype wire

// ==== rtl/counterPortIf.sv ====
`default_nettype none

interface counterPortIf import predictorCfgPkg::*, counterPkg::*;;

  // Execute side: the entry under update and its next value
  tableIndex_t   xIndex;
  counterState_t xCounter;
  logic          writeEn;
  counterState_t writeCounter;

  // Decode side: the entry used for the prediction
  tableIndex_t   dIndex;
  counterState_t dCounter;

  modport updater (
    output xIndex,
    output writeEn,
    output writeCounter,
    input  xCounter
  );

  modport tablePort (
    input  xIndex,
    input  dIndex,
    input  writeEn,
    input  writeCounter,
    output xCounter,
    output dCounter
  );

  // Lookup also watches the write so that it can forward it
  modport lookup (
    output dIndex,
    input  dCounter,
    input  xIndex,
    input  writeEn,
    input  writeCounter
  );

endinterface

`default_nettype wire

// ==== rtl/counterTable.sv ====
`default_nettype none

module counterTable import predictorCfgPkg::*, counterPkg::*; (
  input  logic           clock,
  input  logic           arstN,
  counterPortIf.tablePort port
);

  counterState_t counters [tableDepth];

  logic [tableDepth-1:0] entryWrite;

  // One-hot select of the entry written at the next edge
  always_comb begin
    entryWrite = '0;
    if (port.writeEn) begin
      entryWrite[port.xIndex] = 1'b1;
    end
  end

  for (genvar e = 0; e < tableDepth; e++) begin : gEntry
    always_ff @(posedge clock or negedge arstN) begin
      if (!arstN) begin
        counters[e] <= counterResetState;
      end else if (entryWrite[e]) begin
        counters[e] <= port.writeCounter;
      end
    end
  end

  // Both reads are combinational and show the value from before any pending write
  assign port.xCounter = counters[port.xIndex];
  assign port.dCounter = counters[port.dIndex];

endmodule

`default_nettype wire

// ==== rtl/counterUpdate.sv ====
`default_nettype none

module counterUpdate import predictorCfgPkg::*, counterPkg::*; (
  input  pc_t            xPc,
  input  logic           xBranch,
  input  logic           historyBit,
  input  logic           predictedTaken,
  input  logic           predictedWrong,
  counterPortIf.updater  port
);

  direction_t    predictedDir;
  direction_t    resolvedDir;
  counterState_t stepUp;
  counterState_t stepDown;

  assign port.xIndex = indexOf(xPc);

  // A wrong prediction means the branch went the other way
  assign predictedDir = predictedTaken ? dirTaken : dirNotTaken;
  assign resolvedDir  = predictedWrong ? ~predictedDir : predictedDir;

  // One step toward taken, holding at strongTaken
  always_comb begin
    case (port.xCounter)
      strongNotTaken: stepUp = weakNotTaken;
      weakNotTaken:   stepUp = weakTaken;
      weakTaken:      stepUp = strongTaken;
      default:        stepUp = strongTaken;
    endcase
  end

  // One step toward not taken, holding at strongNotTaken
  always_comb begin
    case (port.xCounter)
      strongTaken:    stepDown = weakTaken;
      weakTaken:      stepDown = weakNotTaken;
      weakNotTaken:   stepDown = strongNotTaken;
      default:        stepDown = strongNotTaken;
    endcase
  end

  assign port.writeCounter = (resolvedDir == dirTaken) ? stepUp : stepDown;

  // Only branches seen with a set history bit train this table
  assign port.writeEn = xBranch && historyBit;

endmodule

`default_nettype wire

// ==== rtl/decodeLookup.sv ====
`default_nettype none

module decodeLookup import predictorCfgPkg::*, counterPkg::*; (
  input  pc_t           dPc,
  input  logic          dBranch,
  output logic          shouldTakeBranch,
  counterPortIf.lookup  port
);

  logic          forwardHit;
  counterState_t selected;

  assign port.dIndex = indexOf(dPc);

  // The table changes only at the edge, so a same-cycle write to this entry
  // is taken straight from the update path
  assign forwardHit = port.writeEn && (port.xIndex == port.dIndex);
  assign selected   = forwardHit ? port.writeCounter : port.dCounter;

  assign shouldTakeBranch = dBranch && predictsTaken(selected);

endmodule

`default_nettype wire

// ==== rtl/predictorCfgPkg.sv ====
`default_nettype none

package predictorCfgPkg;

  // Program counters as they arrive from decode and execute
  localparam int pcWidth = 32;

  // The table is direct mapped on the low bits of the PC
  localparam int indexWidth = 7;
  localparam int tableDepth = 1 << indexWidth;

  typedef logic [pcWidth-1:0]    pc_t;
  typedef logic [indexWidth-1:0] tableIndex_t;

  // Bits above the index are dropped, so PCs that agree in the low bits share an entry
  function automatic tableIndex_t indexOf(input pc_t pc);
    return pc[indexWidth-1:0];
  endfunction

endpackage

`default_nettype wire

// ==== test/clockGen.sv ====
`default_nettype none

module clockGen (
  output logic clock,
  output logic arstN
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int periodNs    = 40;
  localparam int resetCycles = 2;

  initial begin
    clock = 1'b0;
    forever #(periodNs / 2) clock = ~clock;
  end

  // Reset is released on a falling edge, away from the edge that writes the table
  initial begin
    arstN = 1'b0;
    repeat (resetCycles) @(posedge clock);
    @(negedge clock);
    arstN = 1'b1;
  end

endmodule

`default_nettype wire

// ==== test/correlatedPredictorTb.sv ====
`default_nettype none

module correlatedPredictorTb import predictorCfgPkg::*, counterPkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int    clockPeriodNs = 40;
  localparam int    checkDelay    = clockPeriodNs / 2 - 1;
  localparam int    timeoutMargin = 20;
  localparam string goldenPath    = "test/predictorGolden.txt";

  typedef struct packed {
    logic historyBit;
    logic xBranch;
    logic predictedTaken;
    logic predictedWrong;
    pc_t  xPc;
    logic dBranch;
    pc_t  dPc;
    logic expected;
  } goldenVector_t;

  logic clock;
  logic arstN;
  logic historyBit;
  pc_t  xPc;
  logic xBranch;
  logic predictedTaken;
  logic predictedWrong;
  pc_t  dPc;
  logic dBranch;
  logic shouldTakeBranch;

  goldenVector_t vectors [$];

  int   errorCount = 0;
  int   checkCount = 0;
  int   cycleCount = 0;
  int   cycleLimit = 0;
  logic limitReady = 1'b0;
  logic loaded;

  clockGen clockGen_inst (
    .clock (clock),
    .arstN (arstN)
  );

  correlatedPredictor correlatedPredictor_inst (
    .clock            (clock),
    .arstN            (arstN),
    .historyBit       (historyBit),
    .xPc              (xPc),
    .xBranch          (xBranch),
    .predictedTaken   (predictedTaken),
    .predictedWrong   (predictedWrong),
    .dPc              (dPc),
    .dBranch          (dBranch),
    .shouldTakeBranch (shouldTakeBranch)
  );

  task automatic driveIdle();
    historyBit     = 1'b0;
    xPc            = '0;
    xBranch        = 1'b0;
    predictedTaken = 1'b0;
    predictedWrong = 1'b0;
    dPc            = '0;
    dBranch        = 1'b0;
  endtask

  // Lines starting with # are comments, blank lines are skipped
  task automatic loadGolden(output logic ok);
    int            fd;
    int            code;
    int            fields;
    string         line;
    logic          hist;
    logic          xBr;
    logic          pTaken;
    logic          pWrong;
    pc_t           xAddr;
    logic          dBr;
    pc_t           dAddr;
    logic          expTaken;
    goldenVector_t v;
    ok = 1'b1;
    fd = $fopen(goldenPath, "r");
    if (fd == 0) begin
      $display("Could not open the golden file %s", goldenPath);
      ok = 1'b0;
    end else begin
      code = $fgets(line, fd);
      while (code != 0) begin
        if (line.len() > 0 && line.substr(0, 0) != "#") begin
          fields = $sscanf(line, "%h %h %h %h %h %h %h %h",
                           hist, xBr, pTaken, pWrong, xAddr, dBr, dAddr, expTaken);
          if (fields == 8) begin
            v = '{hist, xBr, pTaken, pWrong, xAddr, dBr, dAddr, expTaken};
            vectors.push_back(v);
          end else if (fields > 0) begin
            $display("The golden file has a malformed line: %s", line);
            ok = 1'b0;
          end
        end
        code = $fgets(line, fd);
      end
      $fclose(fd);
      if (vectors.size() == 0) begin
        $display("The golden file %s holds no vectors", goldenPath);
        ok = 1'b0;
      end
    end
  endtask

  task automatic applyVector(input goldenVector_t v);
    historyBit     = v.historyBit;
    xBranch        = v.xBranch;
    predictedTaken = v.predictedTaken;
    predictedWrong = v.predictedWrong;
    xPc            = v.xPc;
    dBranch        = v.dBranch;
    dPc            = v.dPc;
  endtask

  // Every entry must come out of reset as strong not taken
  task automatic checkResetState();
    counterState_t state;
    for (int e = 0; e < tableDepth; e++) begin
      state = correlatedPredictor_inst.counterTable_inst.counters[e];
      checkCount++;
      assert (state == strongNotTaken)
      else begin
        errorCount++;
        $display("Error at %0t ns: entry %0d is %s after reset, expected strongNotTaken",
                 $time, e, state.name());
      end
    end
  endtask

  task automatic checkPrediction(input int n, input goldenVector_t v);
    checkCount++;
    assert (shouldTakeBranch === v.expected)
    else begin
      errorCount++;
      $display("Error at %0t ns: vector %0d dPc %h predicted %b, expected %b",
               $time, n, v.dPc, shouldTakeBranch, v.expected);
    end
  endtask

  initial begin
    driveIdle();
    loadGolden(loaded);
    if (!loaded) begin
      $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
      $display("TESTBENCH FAILED");
      $finish;
    end else begin
      cycleLimit = vectors.size() + timeoutMargin;
      limitReady = 1'b1;
      @(posedge arstN);
      checkResetState();
      for (int n = 0; n < vectors.size(); n++) begin
        @(negedge clock);
        applyVector(vectors[n]);
        #(checkDelay);
        checkPrediction(n, vectors[n]);
      end
      @(negedge clock);
      driveIdle();
      $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
        $display("TESTBENCH PASSED");
      end else begin
        $display("TESTBENCH FAILED");
      end
      $finish;
    end
  end

  initial begin
    wait (limitReady);
    while (cycleCount < cycleLimit) begin
      @(posedge clock);
      cycleCount++;
    end
    $display("The run did not finish within %0d cycles", cycleLimit);
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/predictorGolden.txt ====
# historyBit xBranch predictedTaken predictedWrong xPc dBranch dPc expectedShouldTakeBranch
# All fields hex, one vector per cycle, expected value is the same-cycle prediction
0 0 0 0 00000000 1 00000010 0
0 0 0 0 00000000 1 7fffff7f 0
0 0 0 0 00000000 1 00000024 0
1 1 1 0 00000010 1 00000024 0
0 0 0 0 00000000 1 00000010 0
1 1 1 0 00000010 1 00000024 0
0 0 0 0 00000000 1 00000010 1
1 1 1 0 00000010 1 00000024 0
1 1 1 0 00000010 1 00000024 0
0 0 0 0 00000000 1 00000010 1
1 1 0 0 00000010 1 00000024 0
0 0 0 0 00000000 1 00000010 1
1 1 0 0 00000010 1 00000024 0
0 0 0 0 00000000 1 00000010 0
1 1 0 0 00000010 1 00000024 0
1 1 0 0 00000010 1 00000024 0
0 0 0 0 00000000 1 00000010 0
1 1 0 1 00000024 1 00000010 0
1 1 0 1 00000024 1 00000010 0
0 0 0 0 00000000 1 00000024 1
1 1 1 1 00000024 1 00000010 0
0 0 0 0 00000000 1 00000024 0
0 1 1 0 00000024 1 00000010 0
0 1 1 0 00000024 1 00000010 0
1 0 1 0 00000024 1 00000010 0
0 0 0 0 00000000 1 00000024 0
0 1 1 0 00000024 1 00000024 0
1 1 1 0 00000024 1 00000024 1
1 1 1 0 00000010 1 00000055 0
1 1 1 0 00000010 1 00000090 1
1 1 0 0 00000024 1 00000024 0
1 1 1 0 00000024 1 00000010 1
0 0 0 0 00000000 0 00000010 0
1 1 1 0 00000024 0 00000024 0
0 0 0 0 00000000 1 12345690 1
0 0 0 0 00000000 1 ffffff90 1
1 1 0 0 abcdef10 1 00000055 0
0 0 0 0 00000000 1 00000010 0
0 0 0 0 00000000 1 00000024 1
0 0 0 0 00000000 0 00000024 0
